// File: Bender.yml
package:
  name: wdog_frc

sources:
  - wdog_reg_pkg.sv
  - wdog_cnt_pkg.sv
  - wdog_apb_regs.sv
  - wdog_down_counter.sv
  - wdog_status.sv
  - wdog_frc.sv
  - target: test
    files:
      - wdog_frc_properties.sv
      - tb_wdog_frc.sv

// File: tb_wdog_frc.sv
module tb_wdog_frc;

  import wdog_reg_pkg::*;
  import wdog_cnt_pkg::*;

  // Expected outputs for one point in a counting phase
  typedef struct packed {
    count_t      count;
    logic [15:0] wraps;
    logic        ris;
    logic        intr;
    logic        res;
  } expect_t;

  // Load values used by the test phases
  localparam count_t LOAD_A = 32'd6;
  localparam count_t LOAD_B = 32'd5;
  localparam count_t LOAD_C = 32'd7;
  // Run length limit in PCLK cycles
  localparam int LIMIT = 20 * int'(LOAD_A + LOAD_B + LOAD_C) + 500;

  // DUT ports
  logic       PCLK;
  logic       PRESETn;
  logic       PENABLE;
  apb_addr_t  PADDR;
  logic       PWRITE;
  apb_data_t  PWDATA;
  logic       frc_sel;
  logic       wdog_lock;
  logic       WDOGCLKEN;
  logic       WDOGINT;
  logic       WDOGRES;
  apb_data_t  frc_data;

  // Strobe source and compare state
  logic [15:0] lfsr;
  logic        strobe_on;
  logic        checking;
  logic        strobe_seen;
  int          strobes;
  count_t      ph_load;
  wdog_ctrl_t  ph_ctrl;
  expect_t     exp_now;
  int          cycles;
  apb_data_t   rd;

  wdog_frc wdog_frc_inst (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .PENABLE   (PENABLE),
    .PADDR     (PADDR),
    .PWRITE    (PWRITE),
    .PWDATA    (PWDATA),
    .frc_sel   (frc_sel),
    .wdog_lock (wdog_lock),
    .WDOGCLKEN (WDOGCLKEN),
    .WDOGINT   (WDOGINT),
    .WDOGRES   (WDOGRES),
    .frc_data  (frc_data)
  );

  initial
  begin
    PCLK = 1'b0;
    forever #50 PCLK = ~PCLK;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Expected state k strobes after the strobe that took load
  // Period is load+1, first wrap at k = load
  function automatic expect_t ref_model(input count_t load, input int k, input wdog_ctrl_t c);
    expect_t e;
    int      period;
    period  = int'(load) + 1;
    e.count = load - count_t'(k % period);
    e.wraps = 16'((k + 1) / period);
    e.ris   = (k >= period);
    e.res   = 1'b0;
    // Second wrap with res_en fires the reset, count parks on the reload
    if (c.res_en && k >= 2 * period)
    begin
      e.count = load;
      e.wraps = 16'd2;
      e.res   = 1'b1;
    end
    e.intr = e.ris & c.int_en;
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAIL time %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Setup cycle then enable cycle
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge PCLK);
    frc_sel <= 1'b1;
    PWRITE  <= 1'b1;
    PENABLE <= 1'b0;
    PADDR   <= addr;
    PWDATA  <= data;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    @(posedge PCLK);
    frc_sel <= 1'b0;
    PWRITE  <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    @(posedge PCLK);
    frc_sel <= 1'b1;
    PWRITE  <= 1'b0;
    PENABLE <= 1'b0;
    PADDR   <= addr;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    @(negedge PCLK);
    data = frc_data;
    @(posedge PCLK);
    frc_sel <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  // Park the bus on VALUE and let random strobes run
  task automatic run_count(input count_t load, input wdog_ctrl_t c, input int target);
    @(posedge PCLK);
    ph_load     = load;
    ph_ctrl     = c;
    strobes     = -1;
    strobe_seen = 1'b0;
    frc_sel     <= 1'b1;
    PWRITE      <= 1'b0;
    PENABLE     <= 1'b0;
    PADDR       <= ADDR_VALUE;
    checking    <= 1'b1;
    strobe_on   <= 1'b1;
    while (strobes < target)
      @(posedge PCLK);
    strobe_on <= 1'b0;
    // Let a strobe already in flight be counted
    repeat (3) @(posedge PCLK);
    checking <= 1'b0;
    frc_sel  <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // Strobe source, compare and timeout
  // ------------------------------------------------------------

  always @(posedge PCLK)
  begin
    if (strobe_on)
    begin
      WDOGCLKEN <= lfsr[15];
      lfsr      <= lfsr_next(lfsr);
    end
    else
    begin
      WDOGCLKEN <= 1'b0;
    end
  end

  // Checks after every strobe, outputs are settled at the falling edge
  always @(negedge PCLK)
  begin
    if (checking)
    begin
      if (strobe_seen)
      begin
        strobes = strobes + 1;
        exp_now = ref_model(ph_load, strobes, ph_ctrl);
        check_value("VALUE", frc_data, exp_now.count);
        check_value("WDOGINT", 32'(WDOGINT), 32'(exp_now.intr));
        check_value("WDOGRES", 32'(WDOGRES), 32'(exp_now.res));
      end
      strobe_seen = WDOGCLKEN;
    end
  end

  always @(posedge PCLK)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("Timeout, the run did not finish within %0d cycles", LIMIT);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial
  begin
    lfsr        = 16'd5;
    cycles      = 0;
    strobes     = -1;
    strobe_seen = 1'b0;
    PRESETn     <= 1'b0;
    PENABLE     <= 1'b0;
    PADDR       <= '0;
    PWRITE      <= 1'b0;
    PWDATA      <= '0;
    frc_sel     <= 1'b0;
    wdog_lock   <= 1'b0;
    WDOGCLKEN   <= 1'b0;
    strobe_on   <= 1'b0;
    checking    <= 1'b0;
    repeat (2) @(posedge PCLK);
    PRESETn <= 1'b1;

    // Load and readback, pending load is visible at once
    apb_write(ADDR_CONTROL, 32'h1);
    apb_write(ADDR_LOAD, LOAD_A);
    apb_read(ADDR_VALUE, rd);
    check_value("VALUE", rd, LOAD_A);
    apb_read(ADDR_LOAD, rd);
    check_value("LOAD", rd, LOAD_A);
    apb_read(ADDR_CONTROL, rd);
    check_value("CONTROL", rd, 32'h1);

    // Counting through the first wrap
    run_count(LOAD_A, 2'b01, int'(LOAD_A) + 1);
    apb_read(ADDR_RIS, rd);
    check_value("RIS", rd, 32'h1);
    apb_read(ADDR_MIS, rd);
    check_value("MIS", rd, 32'h1);

    // Mask only, raw status stays
    apb_write(ADDR_CONTROL, 32'h0);
    apb_read(ADDR_MIS, rd);
    check_value("MIS", rd, 32'h0);
    apb_read(ADDR_RIS, rd);
    check_value("RIS", rd, 32'h1);
    check_value("WDOGINT", 32'(WDOGINT), 32'h0);
    apb_write(ADDR_CONTROL, 32'h1);

    // Clear drops everything before any strobe
    apb_write(ADDR_CLEAR, 32'h0);
    @(negedge PCLK);
    check_value("WDOGINT", 32'(WDOGINT), 32'h0);
    apb_read(ADDR_RIS, rd);
    check_value("RIS", rd, 32'h0);
    apb_read(ADDR_MIS, rd);
    check_value("MIS", rd, 32'h0);
    // Clear strobe restarts from the load value
    run_count(LOAD_A, 2'b01, int'(LOAD_A) + 1);

    // Reset at the second wrap, then frozen count
    apb_write(ADDR_CLEAR, 32'h0);
    apb_write(ADDR_LOAD, LOAD_B);
    apb_write(ADDR_CONTROL, 32'h3);
    run_count(LOAD_B, 2'b11, 2 * int'(LOAD_B) + 8);
    apb_read(ADDR_VALUE, rd);
    check_value("VALUE", rd, LOAD_B);
    check_value("WDOGRES", 32'(WDOGRES), 32'h1);

    // Release with res_en low and a new load
    apb_write(ADDR_CONTROL, 32'h1);
    @(negedge PCLK);
    check_value("WDOGRES", 32'(WDOGRES), 32'h0);
    apb_write(ADDR_CLEAR, 32'h0);
    apb_write(ADDR_LOAD, LOAD_C);
    run_count(LOAD_C, 2'b01, int'(LOAD_C) + 1);

    // Locked writes are ignored
    @(posedge PCLK);
    wdog_lock <= 1'b1;
    apb_write(ADDR_LOAD, 32'h55);
    apb_write(ADDR_CONTROL, 32'h2);
    apb_write(ADDR_CLEAR, 32'h0);
    apb_read(ADDR_LOAD, rd);
    check_value("LOAD", rd, LOAD_C);
    apb_read(ADDR_CONTROL, rd);
    check_value("CONTROL", rd, 32'h1);
    apb_read(ADDR_RIS, rd);
    check_value("RIS", rd, 32'h1);
    check_value("WDOGINT", 32'(WDOGINT), 32'h1);
    check_value("WDOGRES", 32'(WDOGRES), 32'h0);
    @(posedge PCLK);
    wdog_lock <= 1'b0;
    @(negedge PCLK);

    // Bound assertions must also have stayed quiet
    if (wdog_frc_inst.wdog_frc_properties_inst.fail_count == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("Assertions in the bound checker failed %0d times",
               wdog_frc_inst.wdog_frc_properties_inst.fail_count);
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
wdog_reg_pkg.sv
wdog_cnt_pkg.sv
wdog_apb_regs.sv
wdog_down_counter.sv
wdog_status.sv
wdog_frc.sv
wdog_frc_properties.sv
tb_wdog_frc.sv

// File: wdog_apb_regs.sv
module wdog_apb_regs (
  input  logic                     PCLK,
  input  logic                     PRESETn,
  input  logic                     PENABLE,
  input  wdog_reg_pkg::apb_addr_t  PADDR,
  input  logic                     PWRITE,
  input  wdog_reg_pkg::apb_data_t  PWDATA,
  input  logic                     frc_sel,
  input  logic                     wdog_lock,
  input  logic                     int_clr_hold,
  output wdog_reg_pkg::wdog_ctrl_t ctrl,
  output wdog_cnt_pkg::count_t     load_value,
  output logic                     load_pulse,
  output logic                     clear_pulse
);

  import wdog_reg_pkg::*;
  import wdog_cnt_pkg::*;

  // Setup phase write, lock honoured
  logic wr_setup;
  // Per-register write strobes
  logic ctrl_wr;
  logic load_wr;
  logic clear_wr;

  // ------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------

  // Writes are taken in the setup cycle, PENABLE still low
  assign wr_setup = frc_sel & PWRITE & ~PENABLE & ~wdog_lock;

  assign ctrl_wr = wr_setup & (PADDR == ADDR_CONTROL);
  assign load_wr = wr_setup & (PADDR == ADDR_LOAD);

  // A clear already held in the status block is not issued again
  assign clear_wr = wr_setup & (PADDR == ADDR_CLEAR) & ~int_clr_hold;

  // ------------------------------------------------------------
  // Control and load registers
  // ------------------------------------------------------------

  // Control bits 1:0 only, upper write data ignored
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      ctrl <= CTRL_RESET;
    end
    else if (ctrl_wr)
    begin
      ctrl <= wdog_ctrl_t'(PWDATA[1:0]);
    end
  end

  // Load register
  // A new write simply overwrites, a pending load picks up the newest value
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      load_value <= LOAD_RESET;
    end
    else if (load_wr)
    begin
      load_value <= count_t'(PWDATA);
    end
  end

  // ------------------------------------------------------------
  // Request pulses
  // ------------------------------------------------------------

  // One cycle each, aligned with the updated register contents
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      load_pulse  <= 1'b0;
      clear_pulse <= 1'b0;
    end
    else
    begin
      load_pulse  <= load_wr;
      clear_pulse <= clear_wr;
    end
  end

endmodule

// File: wdog_cnt_pkg.sv
package wdog_cnt_pkg;

  // ------------------------------------------------------------
  // Counter types
  // ------------------------------------------------------------

  // Count and load value width
  typedef logic [31:0] count_t;

  // Load register and counter start from all ones
  // Keeps the first interrupt as far away as possible
  localparam count_t LOAD_RESET = '1;

  // Counter flags seen by the status logic
  // wrap is high for one strobe period after the count passes zero
  // load_pending is high from the load write until the strobe that takes it
  typedef struct packed {
    logic wrap;
    logic load_pending;
  } cnt_status_t;

endpackage

// File: wdog_down_counter.sv
module wdog_down_counter (
  input  logic                      PCLK,
  input  logic                      PRESETn,
  input  logic                      WDOGCLKEN,
  input  wdog_reg_pkg::wdog_ctrl_t  ctrl,
  input  wdog_cnt_pkg::count_t      load_value,
  input  logic                      load_pulse,
  input  logic                      int_clr_hold,
  input  logic                      wdog_res,
  output wdog_cnt_pkg::cnt_status_t cnt_status,
  output wdog_cnt_pkg::count_t      count_read
);

  import wdog_cnt_pkg::*;

  // Counter state
  count_t count_q;
  count_t count_nxt;
  // Load waiting for the next strobe
  logic   load_pending;
  // int_en as seen on the last strobe
  logic   int_en_prev;
  logic   int_en_rise;
  // Halt after a watchdog reset
  logic   halt_q;
  logic   halted;
  // Next-count selection
  logic   reload;
  logic   dec_en;
  // Passed through zero on the last strobe
  logic   wrap_q;
  logic   wrap_nxt;

  // ------------------------------------------------------------
  // Next-count conditions
  // ------------------------------------------------------------

  // Re-enabling the interrupt restarts the count from the load value
  assign int_en_rise = ctrl.int_en & ~int_en_prev;

  // Reload on a new load, on wrap, on enable, or while a clear is held
  assign reload = load_pending | wrap_q | int_en_rise | int_clr_hold;

  // Reset output stops the count, only a new load lets it go again
  assign halted = wdog_res | (halt_q & ~load_pending);

  assign dec_en = ctrl.int_en & ~halted;

  always_comb
  begin
    // Hold by default, wrap drops on any strobe that does not set it
    count_nxt = count_q;
    wrap_nxt  = 1'b0;
    if (reload)
    begin
      count_nxt = load_value;
      wrap_nxt  = (load_value == '0);
    end
    else if (dec_en)
    begin
      count_nxt = count_q - count_t'(1);
      wrap_nxt  = (count_q == count_t'(1));
    end
  end

  // ------------------------------------------------------------
  // Pending load
  // ------------------------------------------------------------

  // Set after the load pulse, cleared by the strobe that takes it
  // A fresh pulse wins over a strobe in the same cycle
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      load_pending <= 1'b0;
    end
    else if (load_pulse)
    begin
      load_pending <= 1'b1;
    end
    else if (WDOGCLKEN)
    begin
      load_pending <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Strobed state
  // ------------------------------------------------------------

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      count_q     <= LOAD_RESET;
      wrap_q      <= 1'b0;
      halt_q      <= 1'b0;
      int_en_prev <= 1'b0;
    end
    else if (WDOGCLKEN)
    begin
      count_q     <= count_nxt;
      wrap_q      <= wrap_nxt;
      halt_q      <= halted;
      int_en_prev <= ctrl.int_en;
    end
  end

  // Flags for the status block
  assign cnt_status.wrap         = wrap_q;
  assign cnt_status.load_pending = load_pending;

  // Shows a just-written load before any strobe has taken it
  assign count_read = load_pending ? load_value : count_q;

endmodule

// File: wdog_frc.sv
module wdog_frc (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  logic                    PENABLE,
  input  wdog_reg_pkg::apb_addr_t PADDR,
  input  logic                    PWRITE,
  input  wdog_reg_pkg::apb_data_t PWDATA,
  input  logic                    frc_sel,
  input  logic                    wdog_lock,
  input  logic                    WDOGCLKEN,
  output logic                    WDOGINT,
  output logic                    WDOGRES,
  output wdog_reg_pkg::apb_data_t frc_data
);

  import wdog_reg_pkg::*;
  import wdog_cnt_pkg::*;

  // Register block outputs
  wdog_ctrl_t  ctrl;
  count_t      load_value;
  logic        load_pulse;
  logic        clear_pulse;
  // Counter outputs
  cnt_status_t cnt_status;
  count_t      count_read;
  // Fed back from the status block
  logic        int_clr_hold;

  // ------------------------------------------------------------
  // APB writes, control and load
  // ------------------------------------------------------------
  wdog_apb_regs wdog_apb_regs_inst (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .PENABLE      (PENABLE),
    .PADDR        (PADDR),
    .PWRITE       (PWRITE),
    .PWDATA       (PWDATA),
    .frc_sel      (frc_sel),
    .wdog_lock    (wdog_lock),
    .int_clr_hold (int_clr_hold),
    .ctrl         (ctrl),
    .load_value   (load_value),
    .load_pulse   (load_pulse),
    .clear_pulse  (clear_pulse)
  );

  // Down-counter, halted by the reset output
  wdog_down_counter wdog_down_counter_inst (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .WDOGCLKEN    (WDOGCLKEN),
    .ctrl         (ctrl),
    .load_value   (load_value),
    .load_pulse   (load_pulse),
    .int_clr_hold (int_clr_hold),
    .wdog_res     (WDOGRES),
    .cnt_status   (cnt_status),
    .count_read   (count_read)
  );

  // Interrupt, reset and read data
  wdog_status wdog_status_inst (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .WDOGCLKEN    (WDOGCLKEN),
    .ctrl         (ctrl),
    .cnt_status   (cnt_status),
    .clear_pulse  (clear_pulse),
    .count_read   (count_read),
    .load_value   (load_value),
    .PADDR        (PADDR),
    .PWRITE       (PWRITE),
    .frc_sel      (frc_sel),
    .int_clr_hold (int_clr_hold),
    .WDOGINT      (WDOGINT),
    .WDOGRES      (WDOGRES),
    .frc_data     (frc_data)
  );

endmodule

// File: wdog_frc_properties.sv
module wdog_frc_properties (
  input logic                     PCLK,
  input logic                     PRESETn,
  input logic                     WDOGCLKEN,
  input wdog_reg_pkg::wdog_ctrl_t ctrl,
  input logic                     wrap,
  input logic                     ris,
  input logic                     frc_sel,
  input wdog_reg_pkg::apb_data_t  frc_data,
  input logic                     WDOGINT,
  input logic                     WDOGRES
);

  // Number of assertion failures so far
  int fail_count = 0;

  // ------------------------------------------------------------
  // Output rules
  // ------------------------------------------------------------

  // Interrupt pin rises after a strobe that saw wrap, or on unmasking
  int_needs_cause: assert property (@(posedge PCLK) disable iff (!PRESETn)
    $rose(WDOGINT) |-> $past(WDOGCLKEN && wrap) || $rose(ctrl.int_en))
    else
    begin
      fail_count++;
      $error("WDOGINT rose without a wrap strobe or a new int_en");
    end

  // Reset output follows an unserviced raw interrupt
  res_needs_ris: assert property (@(posedge PCLK) disable iff (!PRESETn)
    $rose(WDOGRES) |-> $past(ris))
    else
    begin
      fail_count++;
      $error("WDOGRES rose without a raw interrupt");
    end

  // Read bus idles at zero
  data_idle_zero: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !frc_sel |-> (frc_data == '0))
    else
    begin
      fail_count++;
      $error("frc_data not zero with frc_sel low");
    end

endmodule

bind wdog_frc wdog_frc_properties wdog_frc_properties_inst (
  .PCLK      (PCLK),
  .PRESETn   (PRESETn),
  .WDOGCLKEN (WDOGCLKEN),
  .ctrl      (ctrl),
  .wrap      (cnt_status.wrap),
  .ris       (wdog_status_inst.ris_q),
  .frc_sel   (frc_sel),
  .frc_data  (frc_data),
  .WDOGINT   (WDOGINT),
  .WDOGRES   (WDOGRES)
);

// File: wdog_reg_pkg.sv
package wdog_reg_pkg;

  // ------------------------------------------------------------
  // APB side types
  // ------------------------------------------------------------

  // Word address, taken from PADDR[4:2]
  typedef logic [2:0] apb_addr_t;

  // Full APB data word
  typedef logic [31:0] apb_data_t;

  // ------------------------------------------------------------
  // Register map, word addresses
  // ------------------------------------------------------------

  // Load register, read and write
  localparam apb_addr_t ADDR_LOAD    = 3'd0;
  // Current count, read only
  localparam apb_addr_t ADDR_VALUE   = 3'd1;
  // Control register, read and write
  localparam apb_addr_t ADDR_CONTROL = 3'd2;
  // Interrupt clear, write only
  localparam apb_addr_t ADDR_CLEAR   = 3'd3;
  // Raw interrupt status, read only
  localparam apb_addr_t ADDR_RIS     = 3'd4;
  // Masked interrupt status, read only
  localparam apb_addr_t ADDR_MIS     = 3'd5;

  // Control register fields
  // Bit 1 enables the reset output, bit 0 enables counting and the interrupt
  typedef struct packed {
    logic res_en;
    logic int_en;
  } wdog_ctrl_t;

  // Everything disabled out of reset
  localparam wdog_ctrl_t CTRL_RESET = '0;

endpackage

// File: wdog_status.sv
module wdog_status (
  input  logic                      PCLK,
  input  logic                      PRESETn,
  input  logic                      WDOGCLKEN,
  input  wdog_reg_pkg::wdog_ctrl_t  ctrl,
  input  wdog_cnt_pkg::cnt_status_t cnt_status,
  input  logic                      clear_pulse,
  input  wdog_cnt_pkg::count_t      count_read,
  input  wdog_cnt_pkg::count_t      load_value,
  input  wdog_reg_pkg::apb_addr_t   PADDR,
  input  logic                      PWRITE,
  input  logic                      frc_sel,
  output logic                      int_clr_hold,
  output logic                      WDOGINT,
  output logic                      WDOGRES,
  output wdog_reg_pkg::apb_data_t   frc_data
);

  import wdog_reg_pkg::*;

  // Raw interrupt register
  logic ris_q;
  // Raw status as software sees it
  logic read_ris;
  // Raw status gated by int_en
  logic mis;

  // ------------------------------------------------------------
  // Interrupt clear hold
  // ------------------------------------------------------------

  // wrap may still be high when the clear arrives
  // Holding the clear until wrap is gone stops a second interrupt
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      int_clr_hold <= 1'b0;
    end
    else if (clear_pulse)
    begin
      int_clr_hold <= 1'b1;
    end
    else if (WDOGCLKEN && !cnt_status.wrap)
    begin
      int_clr_hold <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Interrupt
  // ------------------------------------------------------------

  // Set by wrap, kept until cleared, clear has priority
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      ris_q <= 1'b0;
    end
    else if (WDOGCLKEN)
    begin
      ris_q <= (ris_q | cnt_status.wrap) & ~int_clr_hold;
    end
  end

  // A clear shows up at once on reads and on the pin
  assign read_ris = ris_q & ~int_clr_hold;
  assign mis      = read_ris & ctrl.int_en;
  assign WDOGINT  = mis;

  // ------------------------------------------------------------
  // Reset output
  // ------------------------------------------------------------

  // Second wrap with the interrupt still unserviced
  // Dropping res_en releases it without waiting for a strobe
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      WDOGRES <= 1'b0;
    end
    else if (!ctrl.res_en)
    begin
      WDOGRES <= 1'b0;
    end
    else if (WDOGCLKEN && ris_q && cnt_status.wrap)
    begin
      WDOGRES <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Read data
  // ------------------------------------------------------------

  // Zero unless reading a mapped register
  always_comb
  begin
    frc_data = '0;
    if (frc_sel && !PWRITE)
    begin
      case (PADDR)
        ADDR_LOAD:    frc_data = apb_data_t'(load_value);
        ADDR_VALUE:   frc_data = apb_data_t'(count_read);
        ADDR_CONTROL: frc_data[1:0] = ctrl;
        ADDR_RIS:     frc_data[0] = read_ris;
        ADDR_MIS:     frc_data[0] = mis;
        default:      frc_data = '0;
      endcase
    end
  end

endmodule
